/* Bender.yml */
package:
  name: ulpi_link

sources:
  - include_dirs:
      - include
    files:
      - rtl/ulpi_pkg.sv
      - rtl/ulpi_reset.sv
      - rtl/ulpi_reg_port.sv
      - rtl/ulpi_startup.sv
      - rtl/ulpi_rx_status.sv
      - rtl/ulpi_link_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/ulpi_phy_model.sv
      - test/tb_ulpi_link.sv

/* compile.f */
+incdir+include
rtl/ulpi_pkg.sv
rtl/ulpi_reset.sv
rtl/ulpi_reg_port.sv
rtl/ulpi_startup.sv
rtl/ulpi_rx_status.sv
rtl/ulpi_link_top.sv
test/ulpi_phy_model.sv
test/tb_ulpi_link.sv

/* include/ulpi_macros.svh */
`ifndef ULPI_MACROS_SVH
`define ULPI_MACROS_SVH

// phy reset counter, top bit releases ulpi_rst_n after 16 sys_clock edges
`define ULPI_RESET_COUNT_W 5
`define ULPI_USB_RESET_STAGES 3

// phy register map
`define ULPI_ADDR_FUNC_CTRL 6'h04
`define ULPI_ADDR_OTG_CTRL 6'h0A

// full speed, termination on, normal mode, not suspended
`define ULPI_FUNC_CTRL_INIT 8'h45
`define ULPI_OTG_CTRL_INIT 8'h00

// txcmd codes in bits 7:6
`define ULPI_TXCMD_REGWR 2'b10
`define ULPI_TXCMD_REGRD 2'b11

`endif

/* rtl/ulpi_link_top.sv */
`default_nettype none

module ulpi_link_top #(
  parameter bit NEGATE_CLOCK = 1'b0
) (
  input  wire logic                    sys_clock,
  input  wire logic                    areset_n,
  input  wire logic                    ulpi_clk,
  input  wire logic [7:0]              ulpi_data_in,
  input  wire logic                    ulpi_dir,
  input  wire logic                    ulpi_nxt,
  output logic [7:0]                   ulpi_data_out,
  output logic                         ulpi_data_oe,
  output logic                         ulpi_stp,
  output logic                         ulpi_rst_n,
  input  wire logic                    reg_req_valid,
  input  wire ulpi_pkg::ulpi_reg_req_t reg_req,
  output logic                         reg_busy,
  output ulpi_pkg::ulpi_reg_rsp_t      reg_rsp,
  output logic                         usb_reset,
  output logic                         link_ready,
  output logic                         link_error,
  output ulpi_pkg::ulpi_rx_status_t    rx_status
);

  logic                    usb_clock;
  logic                    port_start;
  logic                    port_busy;
  logic                    read_data_cycle;  // keeps reg read data out of rx status
  ulpi_pkg::ulpi_reg_req_t port_req;
  ulpi_pkg::ulpi_reg_rsp_t port_rsp;

  ulpi_reset #(
    .NEGATE_CLOCK(NEGATE_CLOCK)
  ) u_reset (
    .areset_n  (areset_n),
    .sys_clock (sys_clock),
    .ulpi_clk  (ulpi_clk),
    .ulpi_rst_n(ulpi_rst_n),
    .usb_clock (usb_clock),
    .usb_reset (usb_reset)
  );

  ulpi_reg_port u_reg_port (
    .usb_clock      (usb_clock),
    .usb_reset      (usb_reset),
    .start          (port_start),
    .req            (port_req),
    .ulpi_data_in   (ulpi_data_in),
    .ulpi_dir       (ulpi_dir),
    .ulpi_nxt       (ulpi_nxt),
    .busy           (port_busy),
    .rsp            (port_rsp),
    .read_data_cycle(read_data_cycle),
    .ulpi_data_out  (ulpi_data_out),
    .ulpi_data_oe   (ulpi_data_oe),
    .ulpi_stp       (ulpi_stp)
  );

  ulpi_startup u_startup (
    .usb_clock    (usb_clock),
    .usb_reset    (usb_reset),
    .reg_req_valid(reg_req_valid),
    .reg_req      (reg_req),
    .port_busy    (port_busy),
    .port_rsp     (port_rsp),
    .port_start   (port_start),
    .port_req     (port_req),
    .reg_busy     (reg_busy),
    .reg_rsp      (reg_rsp),
    .link_ready   (link_ready),
    .link_error   (link_error)
  );

  ulpi_rx_status u_rx_status (
    .usb_clock      (usb_clock),
    .usb_reset      (usb_reset),
    .ulpi_data_in   (ulpi_data_in),
    .ulpi_dir       (ulpi_dir),
    .ulpi_nxt       (ulpi_nxt),
    .read_data_cycle(read_data_cycle),
    .rx_status      (rx_status)
  );

endmodule

`default_nettype wire

/* rtl/ulpi_pkg.sv */
`default_nettype none

package ulpi_pkg;

  // register access request
  // 15 bits, write flag on top
  typedef struct packed {
    logic       write;  // 1 write, 0 read
    logic [5:0] addr;   // immediate register address
    logic [7:0] wdata;  // ignored on reads
  } ulpi_reg_req_t;

  // register access response
  // done is a single-cycle strobe
  typedef struct packed {
    logic       done;   // transfer finished
    logic [7:0] rdata;  // read result, zero after a write
  } ulpi_reg_rsp_t;

  // decoded rx cmd byte
  // bits 7:6 of the byte carry no status and are dropped
  typedef struct packed {
    logic [1:0] line_state;  // linestate, bits 1:0
    logic [1:0] vbus_state;  // vbus level, bits 3:2
    logic [1:0] rx_event;    // rxactive / rxerror / hostdisc, bits 5:4
  } ulpi_rx_status_t;

endpackage

`default_nettype wire

/* rtl/ulpi_reg_port.sv */
`default_nettype none

`include "ulpi_macros.svh"

module ulpi_reg_port (
  input  wire logic                    usb_clock,
  input  wire logic                    usb_reset,
  input  wire logic                    start,         // one-cycle strobe, only when idle
  input  wire ulpi_pkg::ulpi_reg_req_t req,
  input  wire logic [7:0]              ulpi_data_in,
  input  wire logic                    ulpi_dir,
  input  wire logic                    ulpi_nxt,
  output logic                         busy,
  output ulpi_pkg::ulpi_reg_rsp_t      rsp,
  output logic                         read_data_cycle,  // phy drives register data now
  output logic [7:0]                   ulpi_data_out,
  output logic                         ulpi_data_oe,
  output logic                         ulpi_stp
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_CMD,    // txcmd on the bus, waiting for nxt
    S_ABORT,  // phy grabbed the bus before nxt
    S_WDATA,  // write data on the bus
    S_STP,
    S_RWAIT,  // waiting for dir after read txcmd
    S_RDATA,
    S_REND,   // waiting for dir to drop
    S_DONE
  } state_t;

  state_t                  state;
  state_t                  state_nxt;
  ulpi_pkg::ulpi_reg_req_t req_q;
  logic [7:0]              rdata_q;
  logic                    drive;  // link wants the bus

  always_ff @(posedge usb_clock or posedge usb_reset) begin
    if (usb_reset) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE:  if (start) state_nxt = S_CMD;
      S_CMD: begin
        if (ulpi_dir) begin
          state_nxt = S_ABORT;  // dir wins over nxt
        end else if (ulpi_nxt) begin
          state_nxt = req_q.write ? S_WDATA : S_RWAIT;
        end
      end
      S_ABORT: if (!ulpi_dir) state_nxt = S_CMD;  // retry same request
      S_WDATA: if (!ulpi_dir && ulpi_nxt) state_nxt = S_STP;
      S_STP:   state_nxt = S_DONE;
      S_RWAIT: if (ulpi_dir) state_nxt = S_RDATA;  // this cycle is turnaround
      S_RDATA: state_nxt = S_REND;
      S_REND:  if (!ulpi_dir) state_nxt = S_DONE;
      S_DONE:  state_nxt = S_IDLE;
      default: state_nxt = S_IDLE;
    endcase
  end

  // request held for the whole transfer, retries included
  always_ff @(posedge usb_clock) begin
    if (start && state == S_IDLE) begin
      req_q <= req;
    end
  end

  always_ff @(posedge usb_clock) begin
    if (state == S_RDATA) begin
      rdata_q <= ulpi_data_in;
    end
  end

  always_comb begin
    drive = 1'b0;
    ulpi_data_out = 8'h00;  // stp cycle drives zero
    case (state)
      S_CMD: begin
        drive = 1'b1;
        ulpi_data_out = {req_q.write ? `ULPI_TXCMD_REGWR : `ULPI_TXCMD_REGRD, req_q.addr};
      end
      S_WDATA: begin
        drive = 1'b1;
        ulpi_data_out = req_q.wdata;
      end
      S_STP:   drive = 1'b1;
      default: drive = 1'b0;
    endcase
  end

  assign ulpi_data_oe    = drive && !ulpi_dir;  // turn around at once when phy takes bus
  assign ulpi_stp        = (state == S_STP);
  assign busy            = (state != S_IDLE);
  assign read_data_cycle = (state == S_RDATA);
  assign rsp = '{done: (state == S_DONE), rdata: req_q.write ? 8'h00 : rdata_q};

  // phy only takes the bus from the link while a txcmd waits for nxt
  a_no_drive_on_dir: assert property (
    @(posedge usb_clock) disable iff (usb_reset) ulpi_dir |-> !drive || state == S_CMD
  ) else $error("link still wants the bus while dir high");

  // the startup arbiter must respect busy
  a_start_when_idle: assert property (
    @(posedge usb_clock) disable iff (usb_reset) start |-> !busy
  ) else $error("start while register port busy");

endmodule

`default_nettype wire

/* rtl/ulpi_reset.sv */
`default_nettype none

`include "ulpi_macros.svh"

module ulpi_reset #(
  parameter bit NEGATE_CLOCK = 1'b0  // run the usb logic on the falling ulpi_clk edge
) (
  input  wire logic areset_n,
  input  wire logic sys_clock,
  input  wire logic ulpi_clk,
  output logic      ulpi_rst_n,  // active low, to the phy
  output logic      usb_clock,
  output logic      usb_reset    // active high, usb_clock domain
);

  localparam int CW = `ULPI_RESET_COUNT_W;
  localparam int STAGES = `ULPI_USB_RESET_STAGES;

  logic [CW-1:0]     reset_count;
  logic [STAGES-1:0] reset_delay;

  // no pll here, ulpi_clk is used as is or inverted
  assign usb_clock = NEGATE_CLOCK ? ~ulpi_clk : ulpi_clk;

  // top counter bit doubles as the phy reset release
  assign ulpi_rst_n = reset_count[CW-1];

  // saturating up counter, stops once the top bit is set
  always_ff @(posedge sys_clock or negedge areset_n) begin
    if (!areset_n) begin
      reset_count <= '0;
    end else if (!reset_count[CW-1]) begin
      reset_count <= reset_count + CW'(1);
    end
  end

  // preset while the phy is held, then shift zeros in on usb_clock
  always_ff @(posedge usb_clock or negedge ulpi_rst_n) begin
    if (!ulpi_rst_n) begin
      reset_delay <= '1;
    end else begin
      reset_delay <= {reset_delay[STAGES-2:0], 1'b0};
    end
  end

  assign usb_reset = reset_delay[STAGES-1];  // falls on the 3rd edge after release

  // the usb side must not leave reset before the phy does
  a_usb_reset_order: assert property (
    @(posedge usb_clock) $fell(usb_reset) |-> ulpi_rst_n
  ) else $error("usb_reset released while ulpi_rst_n low");

endmodule

`default_nettype wire

/* rtl/ulpi_rx_status.sv */
`default_nettype none

module ulpi_rx_status (
  input  wire logic                   usb_clock,
  input  wire logic                   usb_reset,
  input  wire logic [7:0]             ulpi_data_in,
  input  wire logic                   ulpi_dir,
  input  wire logic                   ulpi_nxt,
  input  wire logic                   read_data_cycle,  // register read data, not rx cmd
  output ulpi_pkg::ulpi_rx_status_t   rx_status
);

  logic dir_q;    // dir one cycle back
  logic capture;  // byte on the bus is an rx cmd

  always_ff @(posedge usb_clock or posedge usb_reset) begin
    if (usb_reset) begin
      dir_q <= 1'b0;
    end else begin
      dir_q <= ulpi_dir;
    end
  end

  // first dir-high cycle is turnaround
  // nxt high would mean packet data
  assign capture = ulpi_dir && dir_q && !ulpi_nxt && !read_data_cycle;

  always_ff @(posedge usb_clock or posedge usb_reset) begin
    if (usb_reset) begin
      rx_status <= '0;
    end else if (capture) begin
      rx_status <= '{
        line_state: ulpi_data_in[1:0],
        vbus_state: ulpi_data_in[3:2],
        rx_event:   ulpi_data_in[5:4]
      };  // bits 7:6 dropped
    end
  end

endmodule

`default_nettype wire

/* rtl/ulpi_startup.sv */
`default_nettype none

`include "ulpi_macros.svh"

module ulpi_startup (
  input  wire logic                    usb_clock,
  input  wire logic                    usb_reset,
  input  wire logic                    reg_req_valid,  // user request, ignored while busy
  input  wire ulpi_pkg::ulpi_reg_req_t reg_req,
  input  wire logic                    port_busy,
  input  wire ulpi_pkg::ulpi_reg_rsp_t port_rsp,
  output logic                         port_start,
  output ulpi_pkg::ulpi_reg_req_t      port_req,
  output logic                         reg_busy,
  output ulpi_pkg::ulpi_reg_rsp_t      reg_rsp,
  output logic                         link_ready,
  output logic                         link_error
);

  typedef enum logic [2:0] {
    S_FUNC_GO, S_FUNC_WAIT,  // write function control
    S_OTG_GO,  S_OTG_WAIT,   // write otg control
    S_CHK_GO,  S_CHK_WAIT,   // read function control back
    S_READY,
    S_ERROR
  } state_t;

  state_t state;

  always_ff @(posedge usb_clock or posedge usb_reset) begin
    if (usb_reset) begin
      state <= S_FUNC_GO;
    end else begin
      case (state)
        S_FUNC_GO:   if (!port_busy) state <= S_FUNC_WAIT;
        S_FUNC_WAIT: if (port_rsp.done) state <= S_OTG_GO;
        S_OTG_GO:    if (!port_busy) state <= S_OTG_WAIT;
        S_OTG_WAIT:  if (port_rsp.done) state <= S_CHK_GO;
        S_CHK_GO:    if (!port_busy) state <= S_CHK_WAIT;
        S_CHK_WAIT: begin
          if (port_rsp.done) begin
            state <= (port_rsp.rdata == `ULPI_FUNC_CTRL_INIT) ? S_READY : S_ERROR;
          end
        end
        default: state <= state;  // ready and error are sticky
      endcase
    end
  end

  // startup requests first, user path only once ready
  always_comb begin
    port_req = reg_req;
    port_start = 1'b0;
    case (state)
      S_FUNC_GO: begin
        port_req = '{write: 1'b1, addr: `ULPI_ADDR_FUNC_CTRL, wdata: `ULPI_FUNC_CTRL_INIT};
        port_start = !port_busy;
      end
      S_OTG_GO: begin
        port_req = '{write: 1'b1, addr: `ULPI_ADDR_OTG_CTRL, wdata: `ULPI_OTG_CTRL_INIT};
        port_start = !port_busy;
      end
      S_CHK_GO: begin
        port_req = '{write: 1'b0, addr: `ULPI_ADDR_FUNC_CTRL, wdata: 8'h00};
        port_start = !port_busy;
      end
      S_READY: port_start = reg_req_valid && !port_busy;
      default: port_start = 1'b0;
    endcase
  end

  assign link_ready = (state == S_READY);
  assign link_error = (state == S_ERROR);
  assign reg_busy   = port_busy || !link_ready;
  // readback done lands in S_CHK_WAIT, so only user dones pass
  assign reg_rsp = '{done: port_rsp.done && link_ready, rdata: port_rsp.rdata};

  // exactly one outcome, held until reset
  a_outcome_sticky: assert property (
    @(posedge usb_clock) disable iff (usb_reset)
      (link_ready || link_error) |=> (link_ready != link_error) && $stable(link_ready)
  ) else $error("link_ready/link_error not exclusive or not sticky");

endmodule

`default_nettype wire

/* test/tb_ulpi_link.sv */
`default_nettype none

`include "ulpi_macros.svh"

module tb_ulpi_link;

  localparam int TIMEOUT = 200;  // cycles per wait loop

  logic                      sys_clock;
  logic                      areset_n;
  logic                      ulpi_clk;
  logic [7:0]                ulpi_data_in;
  logic                      ulpi_dir;
  logic                      ulpi_nxt;
  logic [7:0]                ulpi_data_out;
  logic                      ulpi_data_oe;
  logic                      ulpi_stp;
  logic                      ulpi_rst_n;
  logic                      reg_req_valid;
  ulpi_pkg::ulpi_reg_req_t   reg_req;
  logic                      reg_busy;
  ulpi_pkg::ulpi_reg_rsp_t   reg_rsp;
  logic                      usb_reset;
  logic                      link_ready;
  logic                      link_error;
  ulpi_pkg::ulpi_rx_status_t rx_status;
  logic                      inject_req;
  logic [7:0]                inject_data;
  logic                      abort_req;
  logic [7:0]                abort_count;

  integer                    seed;
  int                        usb_edges = 0;    // ulpi_clk edges since phy release
  logic [7:0]                shadow [64];      // last value written per address
  logic                      written [64];
  logic [5:0]                addr_list [8];
  ulpi_pkg::ulpi_reg_rsp_t   expected_q [$];   // one entry per outstanding request

  ulpi_link_top #(.NEGATE_CLOCK(1'b0)) UUT (
    .sys_clock(sys_clock), .areset_n(areset_n), .ulpi_clk(ulpi_clk),
    .ulpi_data_in(ulpi_data_in), .ulpi_dir(ulpi_dir), .ulpi_nxt(ulpi_nxt),
    .ulpi_data_out(ulpi_data_out), .ulpi_data_oe(ulpi_data_oe), .ulpi_stp(ulpi_stp),
    .ulpi_rst_n(ulpi_rst_n), .reg_req_valid(reg_req_valid), .reg_req(reg_req),
    .reg_busy(reg_busy), .reg_rsp(reg_rsp), .usb_reset(usb_reset),
    .link_ready(link_ready), .link_error(link_error), .rx_status(rx_status)
  );

  ulpi_phy_model u_phy (
    .ulpi_clk(ulpi_clk), .rst_n(ulpi_rst_n), .data_from_link(ulpi_data_out),
    .data_oe(ulpi_data_oe), .stp(ulpi_stp), .data_to_link(ulpi_data_in),
    .dir(ulpi_dir), .nxt(ulpi_nxt), .inject_req(inject_req), .inject_data(inject_data),
    .abort_req(abort_req), .abort_count(abort_count)
  );

  initial begin
    sys_clock = 1'b0;
    forever #50 sys_clock = ~sys_clock;
  end

  initial begin
    ulpi_clk = 1'b0;
    #30;  // phy clock lags sys_clock
    forever #50 ulpi_clk = ~ulpi_clk;
  end

  always @(posedge ulpi_clk) begin
    if (ulpi_rst_n === 1'b1) usb_edges <= usb_edges + 1;
    else usb_edges <= 0;
  end

  function automatic logic [7:0] reset_value(input logic [5:0] addr);
    return 8'(addr * 37 + 11);  // same fill as the phy model
  endfunction

  function automatic logic [7:0] expected_rdata(input logic [5:0] addr);
    return written[addr] ? shadow[addr] : reset_value(addr);
  endfunction

  function automatic ulpi_pkg::ulpi_rx_status_t expected_rx_status(input logic [7:0] rx_cmd);
    ulpi_pkg::ulpi_rx_status_t s;
    s.line_state = rx_cmd[1:0];
    s.vbus_state = rx_cmd[3:2];
    s.rx_event = rx_cmd[5:4];  // top two bits carry nothing
    return s;
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) report_failure($sformatf("[FAIL] %s: got %h expected %h", name, got, exp));
  endtask

  task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) report_failure($sformatf("[FAIL] %s: got %h expected %h", name, got, exp));
  endtask

  task automatic compare_rsp(input ulpi_pkg::ulpi_reg_rsp_t got,
                             input ulpi_pkg::ulpi_reg_rsp_t exp);
    if (got !== exp) report_failure($sformatf("[FAIL] reg_rsp: got %h expected %h", got, exp));
  endtask

  task automatic compare_rx_status(input ulpi_pkg::ulpi_rx_status_t got,
                                   input ulpi_pkg::ulpi_rx_status_t exp);
    if (got !== exp) report_failure($sformatf("[FAIL] rx_status: got %h expected %h", got, exp));
  endtask

  // response checker, every done must match one queued request
  always @(negedge ulpi_clk) begin
    if (reg_rsp.done === 1'b1) begin
      if (expected_q.size() == 0) begin
        report_failure("reg_rsp.done was raised with no request outstanding.");
      end else begin
        compare_rsp(reg_rsp, expected_q.pop_front());
      end
    end
  end

  task automatic wait_for_dir(input logic level);
    int waited;
    waited = 0;
    @(negedge ulpi_clk);
    while (ulpi_dir !== level) begin
      if (waited == TIMEOUT) report_failure("Timed out waiting for the PHY to change dir.");
      waited++;
      @(negedge ulpi_clk);
    end
  endtask

  task automatic issue_request(input logic is_write, input logic [5:0] addr,
                               input logic [7:0] wdata, input logic with_abort);
    int waited;
    ulpi_pkg::ulpi_reg_rsp_t exp;
    waited = 0;
    @(negedge ulpi_clk);
    while (reg_busy) begin
      if (waited == TIMEOUT) report_failure("Timed out waiting for reg_busy to drop.");
      waited++;
      @(negedge ulpi_clk);
    end
    exp.done = 1'b1;
    exp.rdata = is_write ? 8'h00 : expected_rdata(addr);  // zero after a write
    if (is_write) begin
      shadow[addr] = wdata;
      written[addr] = 1'b1;
    end
    expected_q.push_back(exp);
    @(posedge ulpi_clk);
    reg_req_valid <= 1'b1;
    reg_req <= '{write: is_write, addr: addr, wdata: wdata};
    abort_req <= with_abort;  // phy steals the bus on this txcmd
    @(posedge ulpi_clk);
    reg_req_valid <= 1'b0;
    abort_req <= 1'b0;
    waited = 0;
    while (expected_q.size() != 0) begin
      if (waited == TIMEOUT) report_failure("Timed out waiting for reg_rsp.done.");
      waited++;
      @(negedge ulpi_clk);
    end
  endtask

  task automatic inject_rx(input logic [7:0] rx_cmd);
    @(posedge ulpi_clk);
    inject_req <= 1'b1;
    inject_data <= rx_cmd;
    @(posedge ulpi_clk);
    inject_req <= 1'b0;
    wait_for_dir(1'b1);
    wait_for_dir(1'b0);  // status is registered by now
    compare_rx_status(rx_status, expected_rx_status(rx_cmd));
  endtask

  initial begin
    int edges;
    int waited;
    logic [7:0] data;
    logic [7:0] last_rx;
    seed = 13410;
    last_rx = 8'h00;
    areset_n = 1'b1;
    reg_req_valid = 1'b0;
    reg_req = '0;
    inject_req = 1'b0;
    inject_data = 8'h00;
    abort_req = 1'b0;
    for (int i = 0; i < 64; i++) begin
      shadow[i] = 8'h00;
      written[i] = 1'b0;
    end
    @(posedge sys_clock);
    areset_n <= 1'b0;
    repeat (4) @(posedge sys_clock);
    compare_bit("ulpi_rst_n", ulpi_rst_n, 1'b0);
    compare_bit("usb_reset", usb_reset, 1'b1);
    compare_bit("reg_busy", reg_busy, 1'b1);
    compare_bit("ulpi_data_oe", ulpi_data_oe, 1'b0);
    areset_n <= 1'b1;

    // phy reset release, then usb side
    edges = 0;
    do begin
      @(posedge sys_clock);
      edges++;
      @(negedge sys_clock);
      if (edges > 40) report_failure("Timed out waiting for ulpi_rst_n to rise.");
    end while (!ulpi_rst_n);
    compare_byte("ulpi_rst_n release edge", 8'(edges), 8'd16);
    waited = 0;
    while (usb_reset) begin
      if (waited == TIMEOUT) report_failure("Timed out waiting for usb_reset to fall.");
      waited++;
      @(negedge ulpi_clk);
    end
    compare_byte("usb_reset release edge", 8'(usb_edges), 8'd3);

    // startup programming and readback
    waited = 0;
    while (!link_ready && !link_error) begin
      if (waited == TIMEOUT) report_failure("Timed out waiting for the link to come up.");
      waited++;
      @(negedge ulpi_clk);
    end
    compare_bit("link_ready", link_ready, 1'b1);
    compare_bit("link_error", link_error, 1'b0);
    compare_bit("reg_busy", reg_busy, 1'b0);
    compare_byte("phy func ctrl", u_phy.regs[`ULPI_ADDR_FUNC_CTRL], 8'h45);
    compare_byte("phy otg ctrl", u_phy.regs[`ULPI_ADDR_OTG_CTRL], 8'h00);
    shadow[`ULPI_ADDR_FUNC_CTRL] = 8'h45;
    written[`ULPI_ADDR_FUNC_CTRL] = 1'b1;
    shadow[`ULPI_ADDR_OTG_CTRL] = 8'h00;
    written[`ULPI_ADDR_OTG_CTRL] = 1'b1;

    // random writes, then read them all back
    for (int i = 0; i < 8; i++) begin
      addr_list[i] = 6'($random(seed));
      data = 8'($random(seed));
      issue_request(1'b1, addr_list[i], data, 1'b0);
    end
    for (int i = 0; i < 8; i++) issue_request(1'b0, addr_list[i], 8'h00, 1'b0);

    // rx cmd decoding, reads must leave it alone
    for (int i = 0; i < 6; i++) begin
      last_rx = 8'($random(seed));
      inject_rx(last_rx);
    end
    issue_request(1'b0, addr_list[0], 8'h00, 1'b0);
    issue_request(1'b0, `ULPI_ADDR_FUNC_CTRL, 8'h00, 1'b0);
    compare_rx_status(rx_status, expected_rx_status(last_rx));

    // aborted txcmd, retried by the port
    data = 8'($random(seed));
    issue_request(1'b1, 6'h15, data, 1'b1);
    compare_byte("abort_count", abort_count, 8'd1);
    compare_byte("phy reg 0x15", u_phy.regs[6'h15], data);
    issue_request(1'b0, 6'h15, 8'h00, 1'b1);
    compare_byte("abort_count", abort_count, 8'd2);
    compare_rx_status(rx_status, expected_rx_status(last_rx));

    repeat (4) @(negedge ulpi_clk);  // catch a stray done
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* test/ulpi_phy_model.sv */
`default_nettype none

`include "ulpi_macros.svh"

module ulpi_phy_model (
  input  wire logic       ulpi_clk,
  input  wire logic       rst_n,           // ulpi_rst_n from the link
  input  wire logic [7:0] data_from_link,
  input  wire logic       data_oe,
  input  wire logic       stp,
  output logic [7:0]      data_to_link,
  output logic            dir,
  output logic            nxt,
  input  wire logic       inject_req,      // strobe, send one rx cmd when idle
  input  wire logic [7:0] inject_data,
  input  wire logic       abort_req,       // strobe, steal the bus on the next txcmd
  output logic [7:0]      abort_count
);

  typedef enum logic [3:0] {
    M_IDLE, M_CMD, M_WACK, M_WDATA, M_WSTP, M_RACK, M_RTURN, M_RDATA, M_HOLD
  } model_state_t;

  model_state_t state;
  logic [7:0]   regs [64];
  logic         cmd_write;
  logic [5:0]   cmd_addr;
  logic [1:0]   wait_cnt;        // nxt delay
  logic [1:0]   hold_cnt;        // dir high time
  logic [7:0]   rx_last;         // driven whenever dir is high outside reads
  logic         inject_pending;
  logic [7:0]   inject_byte;
  logic         abort_pending;
  integer       seed;

  initial seed = 13410;

  always @(posedge ulpi_clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= M_IDLE;
      dir <= 1'b0;
      nxt <= 1'b0;
      data_to_link <= 8'h00;
      rx_last <= 8'h00;
      inject_pending <= 1'b0;
      abort_pending <= 1'b0;
      abort_count <= 8'h00;
      for (int i = 0; i < 64; i++) begin
        regs[i] <= 8'(i * 37 + 11);  // power-up content, unique per address
      end
    end else begin
      if (inject_req) begin
        inject_pending <= 1'b1;
        inject_byte <= inject_data;
      end
      if (abort_req) abort_pending <= 1'b1;
      case (state)
        M_IDLE: begin
          if (data_oe && (data_from_link[7:6] == `ULPI_TXCMD_REGWR ||
                          data_from_link[7:6] == `ULPI_TXCMD_REGRD)) begin
            cmd_write <= (data_from_link[7:6] == `ULPI_TXCMD_REGWR);
            cmd_addr <= data_from_link[5:0];
            wait_cnt <= 2'($unsigned($random(seed)) % 3);  // 0 to 2 cycles
            state <= M_CMD;
          end else if (inject_pending && !data_oe) begin
            inject_pending <= 1'b0;
            rx_last <= inject_byte;
            data_to_link <= inject_byte;
            dir <= 1'b1;
            hold_cnt <= 2'd1;  // turnaround + one rx cmd cycle
            state <= M_HOLD;
          end
        end
        M_CMD: begin
          if (abort_pending) begin
            abort_pending <= 1'b0;
            abort_count <= abort_count + 8'd1;
            data_to_link <= rx_last;  // status stays as it was
            dir <= 1'b1;
            hold_cnt <= 2'd2;
            state <= M_HOLD;
          end else if (wait_cnt == 2'd0) begin
            nxt <= 1'b1;
            state <= cmd_write ? M_WACK : M_RACK;
          end else begin
            wait_cnt <= wait_cnt - 2'd1;
          end
        end
        M_WACK:  state <= M_WDATA;  // nxt stays high for the data byte
        M_WDATA: begin
          regs[cmd_addr] <= data_from_link;
          nxt <= 1'b0;
          state <= M_WSTP;
        end
        M_WSTP:  if (stp) state <= M_IDLE;
        M_RACK: begin
          nxt <= 1'b0;
          dir <= 1'b1;
          state <= M_RTURN;
        end
        M_RTURN: begin
          data_to_link <= regs[cmd_addr];
          state <= M_RDATA;
        end
        M_RDATA: begin
          dir <= 1'b0;
          data_to_link <= rx_last;
          state <= M_IDLE;
        end
        M_HOLD: begin
          if (hold_cnt == 2'd0) begin
            dir <= 1'b0;
            state <= M_IDLE;
          end else begin
            hold_cnt <= hold_cnt - 2'd1;
          end
        end
        default: state <= M_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire
